/* Bender.yml */
package:
  name: backprop_layer

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - nn_types_pkg.sv
      - nn_ctrl_pkg.sv
      - layer_feeder.sv
      - neuron_update.sv
      - layer_collector.sv
      - backprop_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_backprop_top.sv

/* backprop_layer.f */
+incdir+.
nn_types_pkg.sv
nn_ctrl_pkg.sv
layer_feeder.sv
neuron_update.sv
layer_collector.sv
backprop_top.sv
tb_backprop_top.sv

/* backprop_top.sv */
`timescale 1ns/10ps
`include "nn_defines.svh"

module backprop_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wr_en,
    input  logic [`HOST_ADDR_WIDTH-1:0]   wr_addr,
    input  nn_types_pkg::host_word_u      wr_data,
    input  logic [`HOST_ADDR_WIDTH-1:0]   rd_addr,
    input  logic                          start,
    output nn_types_pkg::delta_t          rd_data,
    output logic                          busy,
    output logic                          done
);

    ////////////////////////////////////////
    // Interconnect
    ////////////////////////////////////////

    // Feeder to columns
    logic [`NEURON_NUM-1:0]      col_wr_en;
    logic [`INDEX_WIDTH-1:0]     col_wr_index;
    nn_types_pkg::weight_t       col_wr_weight;
    nn_types_pkg::delta_t        delta [0:`NEURON_NUM-1];
    logic                        step_en;
    logic [`INDEX_WIDTH-1:0]     step_index;
    nn_types_pkg::activation_t   step_act;
    logic                        step_last;

    // Columns to collector, only column 0 timing is used
    nn_types_pkg::product_t      back_product  [0:`NEURON_NUM-1];
    logic                        product_valid [0:`NEURON_NUM-1];
    logic [`INDEX_WIDTH-1:0]     product_index [0:`NEURON_NUM-1];
    nn_types_pkg::weight_t       rd_weight     [0:`NEURON_NUM-1];

    layer_feeder feeder (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .start         (start),
        .busy          (busy),
        .col_wr_en     (col_wr_en),
        .col_wr_index  (col_wr_index),
        .col_wr_weight (col_wr_weight),
        .delta         (delta),
        .step_en       (step_en),
        .step_index    (step_index),
        .step_act      (step_act),
        .step_last     (step_last)
    );

    // One column per output neuron j
    for (genvar j = 0; j < `NEURON_NUM; j++) begin : g_column
        neuron_update column (
            .clk           (clk),
            .reset         (reset),
            .wr_en         (col_wr_en[j]),
            .wr_index      (col_wr_index),
            .wr_weight     (col_wr_weight),
            .delta         (delta[j]),
            .step_en       (step_en),
            .step_index    (step_index),
            .step_act      (step_act),
            .rd_index      (rd_addr[nn_ctrl_pkg::ADDR_COL_LSB +: `INDEX_WIDTH]),
            .rd_weight     (rd_weight[j]),
            .back_product  (back_product[j]),
            .product_valid (product_valid[j]),
            .product_index (product_index[j])
        );
    end

    layer_collector collector (
        .clk           (clk),
        .reset         (reset),
        .back_product  (back_product),
        .product_valid (product_valid[0]),
        .product_index (product_index[0]),
        .step_last     (step_last),
        .rd_weight     (rd_weight),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .done          (done)
    );

endmodule

/* layer_collector.sv */
`timescale 1ns/10ps
`include "nn_defines.svh"

module layer_collector (
    input  logic                          clk,
    input  logic                          reset,
    input  nn_types_pkg::product_t        back_product [0:`NEURON_NUM-1],
    input  logic                          product_valid,
    input  logic [`INDEX_WIDTH-1:0]       product_index,
    input  logic                          step_last,
    input  nn_types_pkg::weight_t         rd_weight [0:`NEURON_NUM-1],
    input  logic [`HOST_ADDR_WIDTH-1:0]   rd_addr,
    output nn_types_pkg::delta_t          rd_data,
    output logic                          done
);

    // Sum of NEURON_NUM products needs index width of headroom
    localparam int SUM_WIDTH = `DELTA_CELL_WIDTH + `WEIGHT_CELL_WIDTH + `INDEX_WIDTH;

    // Delta range in sum width
    localparam logic signed [SUM_WIDTH-1:0] D_MAX = (2 ** (`DELTA_CELL_WIDTH - 1)) - 1;
    localparam logic signed [SUM_WIDTH-1:0] D_MIN = -(2 ** (`DELTA_CELL_WIDTH - 1));

    // Back error vector e_i
    nn_types_pkg::delta_t          error [0:`NEURON_NUM-1];

    logic signed [SUM_WIDTH-1:0]   sum;
    logic signed [SUM_WIDTH-1:0]   sum_shift;
    nn_types_pkg::delta_t          e_value;
    logic                          last_q;

    nn_ctrl_pkg::region_e          rd_region;
    logic [`INDEX_WIDTH-1:0]       rd_row;
    logic [`INDEX_WIDTH-1:0]       rd_col;

    ////////////////////////////////////////
    // Error accumulation
    ////////////////////////////////////////

    // Adder tree over all columns
    always_comb begin
        sum = '0;
        for (int j = 0; j < `NEURON_NUM; j++) begin
            sum = sum + back_product[j];
        end
    end

    assign sum_shift = sum >>> `FRACTION_WIDTH;

    always_comb begin
        if (sum_shift > D_MAX) begin
            e_value = nn_types_pkg::delta_t'(D_MAX);
        end else if (sum_shift < D_MIN) begin
            e_value = nn_types_pkg::delta_t'(D_MIN);
        end else begin
            e_value = nn_types_pkg::delta_t'(sum_shift);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < `NEURON_NUM; k++) begin
                error[k] <= '0;
            end
        end else if (product_valid && (product_index < `NEURON_NUM)) begin
            error[product_index] <= e_value;
        end
    end

    // step_last lines up with the product one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            last_q <= 1'b0;
            done   <= 1'b0;
        end else begin
            last_q <= step_last;
            done   <= product_valid && last_q;
        end
    end

    ////////////////////////////////////////
    // Host read port
    ////////////////////////////////////////

    assign rd_region = nn_ctrl_pkg::region_e'(rd_addr[nn_ctrl_pkg::ADDR_REGION_LSB +: 2]);
    assign rd_row    = rd_addr[nn_ctrl_pkg::ADDR_ROW_LSB +: `INDEX_WIDTH];
    assign rd_col    = rd_addr[nn_ctrl_pkg::ADDR_COL_LSB +: `INDEX_WIDTH];

    // Columns already muxed by column index, pick the row here
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data <= '0;
        end else begin
            rd_data <= '0;
            case (rd_region)
                nn_ctrl_pkg::REG_WEIGHT: begin
                    if (rd_row < `NEURON_NUM) begin
                        // Sign extend to the read width
                        rd_data <= nn_types_pkg::delta_t'(rd_weight[rd_row]);
                    end
                end
                nn_ctrl_pkg::REG_A_IN: begin
                    if (rd_col < `NEURON_NUM) begin
                        rd_data <= error[rd_col];
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* layer_feeder.sv */
`timescale 1ns/10ps
`include "nn_defines.svh"

module layer_feeder (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wr_en,
    input  logic [`HOST_ADDR_WIDTH-1:0]   wr_addr,
    input  nn_types_pkg::host_word_u      wr_data,
    input  logic                          start,
    output logic                          busy,
    output logic [`NEURON_NUM-1:0]        col_wr_en,
    output logic [`INDEX_WIDTH-1:0]       col_wr_index,
    output nn_types_pkg::weight_t         col_wr_weight,
    output nn_types_pkg::delta_t          delta [0:`NEURON_NUM-1],
    output logic                          step_en,
    output logic [`INDEX_WIDTH-1:0]       step_index,
    output nn_types_pkg::activation_t     step_act,
    output logic                          step_last
);

    // Index of the final input in a sweep
    localparam logic [`INDEX_WIDTH-1:0] LAST_INDEX = `NEURON_NUM - 1;

    // Host loaded vectors
    nn_types_pkg::activation_t a_in   [0:`NEURON_NUM-1];
    nn_types_pkg::activation_t a_out  [0:`NEURON_NUM-1];
    nn_types_pkg::activation_t target [0:`NEURON_NUM-1];

    nn_ctrl_pkg::step_state_e  state;
    nn_ctrl_pkg::region_e      wr_region;
    logic [`INDEX_WIDTH-1:0]   wr_row;
    logic [`INDEX_WIDTH-1:0]   wr_col;
    logic                      host_wr;

    ////////////////////////////////////////
    // Host write decode
    ////////////////////////////////////////

    assign wr_region = nn_ctrl_pkg::region_e'(wr_addr[nn_ctrl_pkg::ADDR_REGION_LSB +: 2]);
    assign wr_row    = wr_addr[nn_ctrl_pkg::ADDR_ROW_LSB +: `INDEX_WIDTH];
    assign wr_col    = wr_addr[nn_ctrl_pkg::ADDR_COL_LSB +: `INDEX_WIDTH];

    // Writes during a step are dropped
    assign host_wr = wr_en && !busy;

    // Weight words go straight to the column owning row j
    always_comb begin
        for (int j = 0; j < `NEURON_NUM; j++) begin
            col_wr_en[j] = host_wr && (wr_region == nn_ctrl_pkg::REG_WEIGHT) && (wr_row == j);
        end
    end

    assign col_wr_index  = wr_col;
    assign col_wr_weight = wr_data.weight;

    // Activation and target words, indexed by column field
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < `NEURON_NUM; k++) begin
                a_in[k]   <= '0;
                a_out[k]  <= '0;
                target[k] <= '0;
            end
        end else if (host_wr && (wr_col < `NEURON_NUM)) begin
            case (wr_region)
                nn_ctrl_pkg::REG_A_IN:   a_in[wr_col]   <= wr_data.act.value;
                nn_ctrl_pkg::REG_A_OUT:  a_out[wr_col]  <= wr_data.act.value;
                nn_ctrl_pkg::REG_TARGET: target[wr_col] <= wr_data.act.value;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////
    // Step sequencer
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= nn_ctrl_pkg::IDLE;
            step_en    <= 1'b0;
            step_index <= '0;
            for (int k = 0; k < `NEURON_NUM; k++) begin
                delta[k] <= '0;
            end
        end else begin
            case (state)
                nn_ctrl_pkg::IDLE: begin
                    if (start) begin
                        state <= nn_ctrl_pkg::DELTA;
                    end
                end
                nn_ctrl_pkg::DELTA: begin
                    // Sigmoid with cross entropy, delta is plain difference
                    for (int j = 0; j < `NEURON_NUM; j++) begin
                        delta[j] <= nn_types_pkg::delta_t'(
                            $signed({1'b0, a_out[j]}) - $signed({1'b0, target[j]}));
                    end
                    step_en    <= 1'b1;
                    step_index <= '0;
                    state      <= nn_ctrl_pkg::SWEEP;
                end
                nn_ctrl_pkg::SWEEP: begin
                    if (step_index == LAST_INDEX) begin
                        step_en <= 1'b0;
                        state   <= nn_ctrl_pkg::FLUSH;
                    end else begin
                        step_index <= step_index + 1'b1;
                    end
                end
                // Lets the collector finish the last index
                nn_ctrl_pkg::FLUSH: begin
                    state <= nn_ctrl_pkg::IDLE;
                end
                default: begin
                    state <= nn_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    assign busy      = (state != nn_ctrl_pkg::IDLE);
    // Index never leaves 0..NEURON_NUM-1
    assign step_act  = a_in[step_index];
    assign step_last = step_en && (step_index == LAST_INDEX);

    // Broadcast only while sweeping
    step_en_in_sweep: assert property (@(posedge clk) disable iff (reset)
        $rose(step_en) |-> (state == nn_ctrl_pkg::SWEEP));

endmodule

/* neuron_update.sv */
`timescale 1ns/10ps
`include "nn_defines.svh"

module neuron_update (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wr_en,
    input  logic [`INDEX_WIDTH-1:0]       wr_index,
    input  nn_types_pkg::weight_t         wr_weight,
    input  nn_types_pkg::delta_t          delta,
    input  logic                          step_en,
    input  logic [`INDEX_WIDTH-1:0]       step_index,
    input  nn_types_pkg::activation_t     step_act,
    input  logic [`INDEX_WIDTH-1:0]       rd_index,
    output nn_types_pkg::weight_t         rd_weight,
    output nn_types_pkg::product_t        back_product,
    output logic                          product_valid,
    output logic [`INDEX_WIDTH-1:0]       product_index
);

    // Weight range in product width
    localparam nn_types_pkg::product_t W_MAX = (2 ** (`WEIGHT_CELL_WIDTH - 1)) - 1;
    localparam nn_types_pkg::product_t W_MIN = -(2 ** (`WEIGHT_CELL_WIDTH - 1));

    // Row j of the weight matrix
    nn_types_pkg::weight_t  row [0:`NEURON_NUM-1];

    nn_types_pkg::weight_t  old_w;
    nn_types_pkg::weight_t  new_w;
    nn_types_pkg::product_t upd_prod;
    nn_types_pkg::product_t upd_shift;
    nn_types_pkg::product_t diff;

    ////////////////////////////////////////
    // Update datapath
    ////////////////////////////////////////

    assign old_w = row[step_index];

    // Activation is unsigned, zero extend before signed multiply
    assign upd_prod  = delta * $signed({1'b0, step_act});
    assign upd_shift = upd_prod >>> (`FRACTION_WIDTH + `LEARNING_RATE_SHIFT);
    assign diff      = old_w - upd_shift;

    // Clamp to weight range
    always_comb begin
        if (diff > W_MAX) begin
            new_w = nn_types_pkg::weight_t'(W_MAX);
        end else if (diff < W_MIN) begin
            new_w = nn_types_pkg::weight_t'(W_MIN);
        end else begin
            new_w = nn_types_pkg::weight_t'(diff);
        end
    end

    // Weight store, step writes win over host
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < `NEURON_NUM; k++) begin
                row[k] <= '0;
            end
        end else if (step_en) begin
            row[step_index] <= new_w;
        end else if (wr_en && (wr_index < `NEURON_NUM)) begin
            row[wr_index] <= wr_weight;
        end
    end

    ////////////////////////////////////////
    // Back error product
    ////////////////////////////////////////

    // Uses the weight before this step's update
    always_ff @(posedge clk) begin
        if (step_en) begin
            back_product  <= old_w * delta;
            product_index <= step_index;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            product_valid <= 1'b0;
        end else begin
            product_valid <= step_en;
        end
    end

    // Host read view
    assign rd_weight = (rd_index < `NEURON_NUM) ? row[rd_index] : '0;

    step_index_in_range: assert property (@(posedge clk) disable iff (reset)
        step_en |-> (step_index < `NEURON_NUM));

endmodule

/* nn_ctrl_pkg.sv */
`include "nn_defines.svh"

package nn_ctrl_pkg;

    ////////////////////////////////////////
    // Host address map
    ////////////////////////////////////////

    // Top two address bits pick the region
    // Weights use row j and column i, vectors use the column field only
    // Reads of REG_A_IN return the back error vector instead
    typedef enum logic [1:0] {
        REG_WEIGHT = 2'd0,
        REG_A_IN   = 2'd1,
        REG_A_OUT  = 2'd2,
        REG_TARGET = 2'd3
    } region_e;

    // Field positions inside a host address
    localparam int ADDR_REGION_LSB = `HOST_ADDR_WIDTH - 2;
    localparam int ADDR_ROW_LSB    = `INDEX_WIDTH;
    localparam int ADDR_COL_LSB    = 0;

    // Step sequencer
    typedef enum logic [1:0] {
        IDLE,
        DELTA,
        SWEEP,
        FLUSH
    } step_state_e;

endpackage

/* nn_defines.svh */
`ifndef NN_DEFINES_SVH
`define NN_DEFINES_SVH

////////////////////////////////////////
// Layer geometry
////////////////////////////////////////

// Neurons in the layer, also inputs per neuron
`define NEURON_NUM 5

// Bits for a neuron or input index
`define INDEX_WIDTH 3

////////////////////////////////////////
// Fixed point
////////////////////////////////////////

// Unsigned activation, 1 integer bit and 8 fraction bits
`define ACTIVATION_WIDTH 9
// Signed delta and back error
`define DELTA_CELL_WIDTH 18
// Signed weight
`define WEIGHT_CELL_WIDTH 16
// Fraction bits shared by all formats
`define FRACTION_WIDTH 8
// Learning rate as a power of two divider
`define LEARNING_RATE_SHIFT 0

// Region, row and column of a host address
`define HOST_ADDR_WIDTH 8

`endif

/* nn_types_pkg.sv */
`include "nn_defines.svh"

package nn_types_pkg;

    ////////////////////////////////////////
    // Fixed point words
    ////////////////////////////////////////

    // Activation or target, always positive
    typedef logic [`ACTIVATION_WIDTH-1:0] activation_t;

    // Delta of an output neuron or back error of an input
    typedef logic signed [`DELTA_CELL_WIDTH-1:0] delta_t;

    // One synapse weight
    typedef logic signed [`WEIGHT_CELL_WIDTH-1:0] weight_t;

    // Full product, wide enough for delta times weight
    typedef logic signed [`DELTA_CELL_WIDTH+`WEIGHT_CELL_WIDTH-1:0] product_t;

    ////////////////////////////////////////
    // Host write word
    ////////////////////////////////////////

    // Same data bits, read as a weight or as an activation by region
    typedef union packed {
        weight_t weight;
        // Activation sits in the low bits, upper bits unused
        struct packed {
            logic [`WEIGHT_CELL_WIDTH-`ACTIVATION_WIDTH-1:0] pad;
            activation_t                                     value;
        } act;
    } host_word_u;

endpackage

/* tb_backprop_top.sv */
`timescale 1ns/10ps
`include "nn_defines.svh"

module tb_backprop_top;

    localparam int N               = `NEURON_NUM;
    localparam int CLK_PERIOD      = 4;
    localparam int NUM_STEPS       = 200;
    // Random steps plus reset, readback and extreme cases
    localparam int NUM_TESTS       = NUM_STEPS + 6;
    localparam int CYCLES_PER_TEST = N * N + 3 * N + N + 10;
    localparam int TIMEOUT_NS      = NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD * 2;
    localparam int DONE_LIMIT      = 4 * N + 20;
    localparam int A_MAX           = (2 ** `ACTIVATION_WIDTH) - 1;
    localparam int W_MAX           = (2 ** (`WEIGHT_CELL_WIDTH - 1)) - 1;
    localparam int W_MIN           = -(2 ** (`WEIGHT_CELL_WIDTH - 1));

    logic                             clk;
    logic                             reset;
    logic                             wr_en;
    logic [`HOST_ADDR_WIDTH-1:0]      wr_addr;
    nn_types_pkg::host_word_u         wr_data;
    logic [`HOST_ADDR_WIDTH-1:0]      rd_addr;
    logic                             start;
    nn_types_pkg::delta_t             rd_data;
    logic                             busy;
    logic                             done;

    // Reference state
    int model_weight [N][N];
    int model_a_in   [N];
    int model_a_out  [N];
    int model_target [N];
    int model_error  [N];

    backprop_top UUT (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .start   (start),
        .rd_data (rd_data),
        .busy    (busy),
        .done    (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out before all tests finished");
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic signed [31:0] got,
                               input logic signed [31:0] expected);
        if (got !== expected) begin
            $display("FAILED %s got %h expected %h", name, got, expected);
            $display("Done: errors found");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    function automatic logic [`HOST_ADDR_WIDTH-1:0] make_addr(
        input nn_ctrl_pkg::region_e region, input int row, input int col);
        logic [`HOST_ADDR_WIDTH-1:0] addr;
        addr = '0;
        addr[nn_ctrl_pkg::ADDR_REGION_LSB +: 2]            = region;
        addr[nn_ctrl_pkg::ADDR_ROW_LSB +: `INDEX_WIDTH]    = row[`INDEX_WIDTH-1:0];
        addr[nn_ctrl_pkg::ADDR_COL_LSB +: `INDEX_WIDTH]    = col[`INDEX_WIDTH-1:0];
        return addr;
    endfunction

    // Clamp to a signed field of the given width
    function automatic int saturate(input longint value, input int width);
        longint hi;
        longint lo;
        hi = (longint'(1) << (width - 1)) - 1;
        lo = -(longint'(1) << (width - 1));
        if (value > hi) begin
            return int'(hi);
        end else if (value < lo) begin
            return int'(lo);
        end
        return int'(value);
    endfunction

    // One training step on the reference state
    function automatic void model_step();
        int     d [N];
        longint sum;
        longint prod;
        for (int j = 0; j < N; j++) begin
            d[j] = model_a_out[j] - model_target[j];
        end
        // Errors take the weights before the update
        for (int i = 0; i < N; i++) begin
            sum = 0;
            for (int j = 0; j < N; j++) begin
                sum += longint'(model_weight[j][i]) * d[j];
            end
            model_error[i] = saturate(sum >>> `FRACTION_WIDTH, `DELTA_CELL_WIDTH);
        end
        for (int j = 0; j < N; j++) begin
            for (int i = 0; i < N; i++) begin
                prod = longint'(d[j]) * model_a_in[i];
                model_weight[j][i] = saturate(longint'(model_weight[j][i]) -
                    (prod >>> (`FRACTION_WIDTH + `LEARNING_RATE_SHIFT)), `WEIGHT_CELL_WIDTH);
            end
        end
    endfunction

    ////////////////////////////////////////
    // Host port tasks, entered on a falling edge
    ////////////////////////////////////////

    task automatic write_word(input logic [`HOST_ADDR_WIDTH-1:0] addr,
                              input nn_types_pkg::host_word_u data);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);
        wr_en   = 1'b0;
    endtask

    task automatic write_weight(input int j, input int i, input int value);
        nn_types_pkg::host_word_u word;
        word.weight = nn_types_pkg::weight_t'(value);
        write_word(make_addr(nn_ctrl_pkg::REG_WEIGHT, j, i), word);
        model_weight[j][i] = value;
    endtask

    task automatic write_vector(input nn_ctrl_pkg::region_e region, input int i,
                                input int value);
        nn_types_pkg::host_word_u word;
        word.act.pad   = '0;
        word.act.value = nn_types_pkg::activation_t'(value);
        write_word(make_addr(region, 0, i), word);
    endtask

    // Data shows one cycle after the address
    task automatic read_word(input logic [`HOST_ADDR_WIDTH-1:0] addr,
                             output logic signed [31:0] value);
        rd_addr = addr;
        @(negedge clk);
        value = rd_data;
    endtask

    task automatic load_vectors(input int a_in_value [N], input int a_out_value [N],
                                input int target_value [N]);
        for (int i = 0; i < N; i++) begin
            write_vector(nn_ctrl_pkg::REG_A_IN, i, a_in_value[i]);
            write_vector(nn_ctrl_pkg::REG_A_OUT, i, a_out_value[i]);
            write_vector(nn_ctrl_pkg::REG_TARGET, i, target_value[i]);
            model_a_in[i]   = a_in_value[i];
            model_a_out[i]  = a_out_value[i];
            model_target[i] = target_value[i];
        end
    endtask

    task automatic load_random(input bit with_weights);
        int a_in_value   [N];
        int a_out_value  [N];
        int target_value [N];
        nn_types_pkg::weight_t w;
        for (int i = 0; i < N; i++) begin
            a_in_value[i]   = $urandom % (A_MAX + 1);
            a_out_value[i]  = $urandom % (A_MAX + 1);
            target_value[i] = $urandom % (A_MAX + 1);
        end
        load_vectors(a_in_value, a_out_value, target_value);
        if (with_weights) begin
            for (int j = 0; j < N; j++) begin
                for (int i = 0; i < N; i++) begin
                    w = nn_types_pkg::weight_t'($urandom);
                    write_weight(j, i, int'(w));
                end
            end
        end
    endtask

    // Start pulse, then count edges up to done while poking the busy DUT
    task automatic run_step();
        int cycles;
        bit seen_done;
        int wj;
        int wi;
        cycles    = 0;
        seen_done = 1'b0;
        wj        = $urandom % N;
        wi        = $urandom % N;
        check_value("busy", busy, 0);
        start = 1'b1;
        while (!seen_done && (cycles < DONE_LIMIT)) begin
            @(negedge clk);
            cycles++;
            start = 1'b0;
            wr_en = 1'b0;
            // Weight write while busy, before any step write to the row
            if (cycles == 1) begin
                wr_en          = 1'b1;
                wr_addr        = make_addr(nn_ctrl_pkg::REG_WEIGHT, wj, wi);
                wr_data.weight = ~nn_types_pkg::weight_t'(model_weight[wj][wi]);
            end
            // Second start, should be ignored
            if (cycles == 2) begin
                start = 1'b1;
            end
            // Activation write while busy, last input still ahead in the sweep
            if (cycles == 3) begin
                wr_en              = 1'b1;
                wr_addr            = make_addr(nn_ctrl_pkg::REG_A_IN, 0, N - 1);
                wr_data.act.pad    = '0;
                wr_data.act.value  = ~nn_types_pkg::activation_t'(model_a_in[N - 1]);
            end
            if (done === 1'b1) begin
                seen_done = 1'b1;
                check_value("busy", busy, 0);
            end else begin
                check_value("busy", busy, 1);
            end
        end
        if (!seen_done) begin
            $display("No done pulse within %0d cycles of start", DONE_LIMIT);
            $display("Done: errors found");
            $fatal(1, "Step never finished");
        end
        // Edges counted from the one that samples start
        check_value("done_latency", cycles, N + 3);
        @(negedge clk);
        check_value("done", done, 0);
        check_value("busy", busy, 0);
    endtask

    task automatic check_results();
        logic signed [31:0] got;
        for (int j = 0; j < N; j++) begin
            for (int i = 0; i < N; i++) begin
                read_word(make_addr(nn_ctrl_pkg::REG_WEIGHT, j, i), got);
                check_value($sformatf("rd_data weight[%0d][%0d]", j, i), got,
                            model_weight[j][i]);
            end
        end
        for (int i = 0; i < N; i++) begin
            read_word(make_addr(nn_ctrl_pkg::REG_A_IN, 0, i), got);
            check_value($sformatf("rd_data error[%0d]", i), got, model_error[i]);
        end
    endtask

    // Flat weights, full-scale inputs
    task automatic run_extreme(input int weight_value, input int a_out_value,
                               input int target_value);
        int a_in_v   [N];
        int a_out_v  [N];
        int target_v [N];
        for (int i = 0; i < N; i++) begin
            a_in_v[i]   = A_MAX;
            a_out_v[i]  = a_out_value;
            target_v[i] = target_value;
        end
        load_vectors(a_in_v, a_out_v, target_v);
        for (int j = 0; j < N; j++) begin
            for (int i = 0; i < N; i++) begin
                write_weight(j, i, weight_value);
            end
        end
        run_step();
        model_step();
        check_results();
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        logic signed [31:0] got;
        nn_types_pkg::weight_t w;
        reset   = 1'b1;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_addr = '0;
        start   = 1'b0;
        void'($urandom(32'h3a97));
        for (int j = 0; j < N; j++) begin
            model_error[j] = 0;
            for (int i = 0; i < N; i++) begin
                model_weight[j][i] = 0;
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Quiet after reset
        check_value("busy", busy, 0);
        check_value("done", done, 0);
        check_value("rd_data", rd_data, 0);
        read_word(make_addr(nn_ctrl_pkg::REG_WEIGHT, 2, 3), got);
        check_value("rd_data weight[2][3]", got, 0);
        read_word(make_addr(nn_ctrl_pkg::REG_A_IN, 0, 1), got);
        check_value("rd_data error[1]", got, 0);

        // Weight write and readback
        for (int j = 0; j < N; j++) begin
            for (int i = 0; i < N; i++) begin
                w = nn_types_pkg::weight_t'($urandom);
                write_weight(j, i, int'(w));
            end
        end
        for (int j = 0; j < N; j++) begin
            for (int i = 0; i < N; i++) begin
                read_word(make_addr(nn_ctrl_pkg::REG_WEIGHT, j, i), got);
                check_value($sformatf("rd_data weight[%0d][%0d]", j, i), got,
                            model_weight[j][i]);
            end
        end

        // Random training steps, weights sometimes carried over
        for (int s = 0; s < NUM_STEPS; s++) begin
            load_random($urandom % 2);
            run_step();
            model_step();
            check_results();
        end

        // Saturation corners
        run_extreme(W_MAX, A_MAX, 0);
        run_extreme(W_MIN, A_MAX, 0);
        run_extreme(W_MAX, 0, A_MAX);

        $display("Done: no errors");
        $finish;
    end

endmodule
